/* common/icache_cfg_pkg.sv */
// instruction cache geometry defaults and the address field widths derived from them
package icache_cfg_pkg;

  ////////////////////////////////////////
  // geometry defaults
  ////////////////////////////////////////

  // associativity, overridable at the top level
  parameter int unsigned NumWaysDef = 4;
  // number of sets, power of two
  parameter int unsigned NumSetsDef = 16;

  ////////////////////////////////////////
  // datapath widths
  ////////////////////////////////////////

  // physical fetch address
  parameter int unsigned AddrWidth  = 32;
  // one cache line, refilled in a single beat
  parameter int unsigned LineWidth  = 128;
  // one instruction word handed to the core
  parameter int unsigned FetchWidth = 32;

  ////////////////////////////////////////
  // derived address fields
  ////////////////////////////////////////

  // byte offset inside a line
  parameter int unsigned OffsetWidth  = $clog2(LineWidth / 8);
  // byte offset inside a fetch word, dropped on lookup
  parameter int unsigned ByteIdxWidth = $clog2(FetchWidth / 8);

  // address layout, msb to lsb
  //   tag | set index | line offset
  // index and tag widths follow from the set count of each instance

endpackage

/* common/icache_mem_pkg.sv */
// message kinds carried on the shared memory return channel of the instruction cache
package icache_mem_pkg;

  ////////////////////////////////////////
  // return channel message kinds
  ////////////////////////////////////////

  // ifill and invalidation share the same channel, so they never
  // arrive in the same cycle
  // the cache consumes every return in its valid cycle
  typedef enum logic {
    // full line for the outstanding refill
    RTRN_IFILL = 1'b0,
    // clear one way of a set, or the whole set with inv_all
    RTRN_INV   = 1'b1
  } rtrn_type_e;

  // an invalidation may hit the set of a pending refill
  // the refill then writes over the cleared entry, which is harmless

endpackage

/* icache/icache_arrays.sv */
// per-way tag/valid and line memories of the instruction cache with one-cycle reads
module icache_arrays #(
  parameter int unsigned NumWays = icache_cfg_pkg::NumWaysDef,
  parameter int unsigned NumSets = icache_cfg_pkg::NumSetsDef,
  localparam int unsigned IdxWidth = $clog2(NumSets),
  localparam int unsigned TagWidth = icache_cfg_pkg::AddrWidth - IdxWidth
                                     - icache_cfg_pkg::OffsetWidth
) (
  input  logic                                               clk_i,
  // lookup
  input  logic                                               rd_en_i,
  input  logic [IdxWidth-1:0]                                index_i,
  // tag/valid write
  input  logic                                               vld_we_i,
  input  logic [IdxWidth-1:0]                                vld_index_i,
  input  logic [NumWays-1:0]                                 vld_way_mask_i,
  input  logic                                               vld_set_i,
  input  logic [TagWidth-1:0]                                tag_i,
  // line write, at the lookup index
  input  logic                                               data_we_i,
  input  logic [NumWays-1:0]                                 data_way_mask_i,
  input  logic [icache_cfg_pkg::LineWidth-1:0]               line_i,
  // read data
  output logic [NumWays-1:0][TagWidth-1:0]                   tag_rdata_o,
  output logic [NumWays-1:0]                                 vld_rdata_o,
  output logic [NumWays-1:0][icache_cfg_pkg::LineWidth-1:0]  line_rdata_o
);

  ////////////////////////////////////////
  // one memory pair per way
  ////////////////////////////////////////

  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    // valid bit sits on top of the tag
    logic [TagWidth:0]                    tv_mem   [NumSets];
    logic [icache_cfg_pkg::LineWidth-1:0] line_mem [NumSets];
    logic [TagWidth:0]                    tv_q;
    logic [icache_cfg_pkg::LineWidth-1:0] line_q;

    always_ff @(posedge clk_i) begin
      if (vld_we_i && vld_way_mask_i[w]) begin
        tv_mem[vld_index_i] <= {vld_set_i, tag_i};
      end
      if (data_we_i && data_way_mask_i[w]) begin
        line_mem[index_i] <= line_i;
      end
      // read data holds until the next lookup
      if (rd_en_i) begin
        tv_q   <= tv_mem[index_i];
        line_q <= line_mem[index_i];
      end
    end

    assign vld_rdata_o[w]  = tv_q[TagWidth];
    assign tag_rdata_o[w]  = tv_q[TagWidth-1:0];
    assign line_rdata_o[w] = line_q;
  end

endmodule

/* icache/icache_way_select.sv */
// tag compare, hit word select and replacement way choice for the instruction cache
module icache_way_select #(
  parameter int unsigned NumWays = icache_cfg_pkg::NumWaysDef,
  parameter int unsigned NumSets = icache_cfg_pkg::NumSetsDef,
  localparam int unsigned WayWidth = $clog2(NumWays),
  localparam int unsigned TagWidth = icache_cfg_pkg::AddrWidth - $clog2(NumSets)
                                     - icache_cfg_pkg::OffsetWidth
) (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  logic [TagWidth-1:0]                                tag_i,
  input  logic [icache_cfg_pkg::OffsetWidth-1:0]             offset_i,
  input  logic [NumWays-1:0][TagWidth-1:0]                   tag_rdata_i,
  input  logic [NumWays-1:0]                                 vld_rdata_i,
  input  logic [NumWays-1:0][icache_cfg_pkg::LineWidth-1:0]  line_rdata_i,
  input  logic                                               lfsr_step_i,
  output logic                                               hit_o,
  output logic [icache_cfg_pkg::FetchWidth-1:0]              hit_word_o,
  output logic [WayWidth-1:0]                                repl_way_o
);

  logic [NumWays-1:0]  hit_vec;
  logic [WayWidth-1:0] hit_way, inv_way;
  logic                all_valid;
  logic [7:0]          lfsr_q;

  ////////////////////////////////////////
  // tag compare and word select
  ////////////////////////////////////////

  for (genvar w = 0; w < NumWays; w++) begin : gen_cmp
    assign hit_vec[w] = vld_rdata_i[w] & (tag_rdata_i[w] == tag_i);
  end

  // scan downwards so the lowest matching way wins
  always_comb begin
    hit_way = '0;
    inv_way = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (hit_vec[w]) hit_way = WayWidth'(w);
      if (!vld_rdata_i[w]) inv_way = WayWidth'(w);
    end
  end

  assign hit_o      = |hit_vec;
  assign hit_word_o = line_rdata_i[hit_way][
      offset_i[icache_cfg_pkg::OffsetWidth-1:icache_cfg_pkg::ByteIdxWidth]
      * icache_cfg_pkg::FetchWidth +: icache_cfg_pkg::FetchWidth];

  ////////////////////////////////////////
  // replacement
  ////////////////////////////////////////

  assign all_valid  = &vld_rdata_i;
  // fill empty ways first, random victim once the set is full
  assign repl_way_o = all_valid ? lfsr_q[WayWidth-1:0] : inv_way;

  // 8 bit maximal length, taps 8 6 5 4
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 8'hA5;
    end else if (lfsr_step_i && all_valid) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

endmodule

/* icache/icache_ctrl.sv */
// instruction cache controller with lookup/refill FSM, flush walker and array control
module icache_ctrl #(
  parameter int unsigned NumWays = icache_cfg_pkg::NumWaysDef,
  parameter int unsigned NumSets = icache_cfg_pkg::NumSetsDef,
  localparam int unsigned IdxWidth = $clog2(NumSets),
  localparam int unsigned WayWidth = $clog2(NumWays),
  localparam int unsigned TagWidth = icache_cfg_pkg::AddrWidth - IdxWidth
                                     - icache_cfg_pkg::OffsetWidth
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   flush_i,
  input  logic                                   fetch_req_i,
  input  logic [icache_cfg_pkg::AddrWidth-1:0]   fetch_addr_i,
  output logic                                   fetch_ready_o,
  output logic                                   fetch_valid_o,
  output logic [icache_cfg_pkg::FetchWidth-1:0]  fetch_data_o,
  output logic                                   mem_req_o,
  output logic [icache_cfg_pkg::AddrWidth-1:0]   mem_addr_o,
  output logic [WayWidth-1:0]                    mem_way_o,
  input  logic                                   mem_ack_i,
  input  logic                                   mem_rtrn_vld_i,
  input  icache_mem_pkg::rtrn_type_e             mem_rtrn_type_i,
  input  logic [icache_cfg_pkg::LineWidth-1:0]   mem_rtrn_data_i,
  input  logic                                   mem_rtrn_inv_all_i,
  input  logic [IdxWidth-1:0]                    mem_rtrn_inv_set_i,
  input  logic [WayWidth-1:0]                    mem_rtrn_inv_way_i,
  output logic                                   miss_o,
  input  logic                                   hit_i,
  input  logic [icache_cfg_pkg::FetchWidth-1:0]  hit_word_i,
  input  logic [WayWidth-1:0]                    repl_way_i,
  output logic                                   rd_en_o,
  output logic [IdxWidth-1:0]                    index_o,
  output logic [TagWidth-1:0]                    tag_o,
  output logic [icache_cfg_pkg::OffsetWidth-1:0] offset_o,
  output logic                                   vld_we_o,
  output logic [NumWays-1:0]                     vld_way_mask_o,
  output logic [IdxWidth-1:0]                    vld_index_o,
  output logic                                   vld_set_o,
  output logic                                   data_we_o,
  output logic [NumWays-1:0]                     data_way_mask_o,
  output logic                                   lfsr_step_o
);

  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} ctrl_state_e;

  ctrl_state_e                          state_d, state_q;
  logic                                 flush_q;
  logic [IdxWidth-1:0]                  flush_cnt_q;
  logic                                 flush_en, flush_done;
  logic                                 inv_en, fill_rtrn, fill_en, accept;
  logic [icache_cfg_pkg::AddrWidth-1:0] addr_q;
  logic [WayWidth-1:0]                  way_q;
  logic [NumWays-1:0]                   way_oh, inv_oh;

  ////////////////////////////////////////
  // request address fields
  ////////////////////////////////////////

  assign accept   = fetch_ready_o & fetch_req_i;
  assign tag_o    = addr_q[icache_cfg_pkg::AddrWidth-1 -: TagWidth];
  assign offset_o = addr_q[icache_cfg_pkg::OffsetWidth-1:0];
  // read with the incoming address, write back with the latched one
  assign index_o  = accept ? fetch_addr_i[icache_cfg_pkg::OffsetWidth +: IdxWidth]
                           : addr_q[icache_cfg_pkg::OffsetWidth +: IdxWidth];

  // refill requests are line aligned
  assign mem_addr_o = {addr_q[icache_cfg_pkg::AddrWidth-1:icache_cfg_pkg::OffsetWidth],
                       {icache_cfg_pkg::OffsetWidth{1'b0}}};
  // way is live in READ and held afterwards for the fill write
  assign mem_way_o  = (state_q == READ) ? repl_way_i : way_q;

  // hit word in READ, word straight out of the returned line in MISS
  assign fetch_data_o = (state_q == MISS)
      ? mem_rtrn_data_i[addr_q[icache_cfg_pkg::OffsetWidth-1:icache_cfg_pkg::ByteIdxWidth]
                        * icache_cfg_pkg::FetchWidth +: icache_cfg_pkg::FetchWidth]
      : hit_word_i;

  ////////////////////////////////////////
  // main FSM
  ////////////////////////////////////////

  assign fill_rtrn = mem_rtrn_vld_i & (mem_rtrn_type_i == icache_mem_pkg::RTRN_IFILL);
  assign inv_en    = mem_rtrn_vld_i & (mem_rtrn_type_i == icache_mem_pkg::RTRN_INV);

  always_comb begin
    state_d       = state_q;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;
    rd_en_o       = 1'b0;
    flush_en      = 1'b0;
    fill_en       = 1'b0;
    unique case (state_q)
      // walk all sets and clear them
      FLUSH: begin
        flush_en = 1'b1;
        if (flush_done) begin
          state_d = IDLE;
        end
      end
      // return cycles block lookups so reads never race a valid write
      IDLE: begin
        if (flush_q) begin
          state_d = FLUSH;
        end else if (!mem_rtrn_vld_i) begin
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            rd_en_o = 1'b1;
            state_d = READ;
          end
        end
      end
      // tags are out, answer a hit or hold the refill request until ack
      READ: begin
        if (hit_i) begin
          fetch_valid_o = 1'b1;
          state_d       = IDLE;
        end else begin
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = 1'b1;
            state_d = MISS;
          end
        end
      end
      // wait for the line, forward the word and write it in
      MISS: begin
        if (fill_rtrn) begin
          fetch_valid_o = 1'b1;
          fill_en       = 1'b1;
          state_d       = IDLE;
        end
      end
      default: state_d = FLUSH;
    endcase
  end

  ////////////////////////////////////////
  // valid and data write control
  ////////////////////////////////////////

  assign flush_done = flush_en & (flush_cnt_q == IdxWidth'(NumSets - 1));
  assign way_oh     = NumWays'(1) << way_q;
  assign inv_oh     = mem_rtrn_inv_all_i ? '1 : NumWays'(1) << mem_rtrn_inv_way_i;

  // flush first, then invalidation, then refill
  assign vld_we_o       = flush_en | inv_en | fill_en;
  assign vld_index_o    = flush_en ? flush_cnt_q
                        : inv_en   ? mem_rtrn_inv_set_i
                        : addr_q[icache_cfg_pkg::OffsetWidth +: IdxWidth];
  assign vld_way_mask_o = flush_en ? '1 : inv_en ? inv_oh : way_oh;
  assign vld_set_o      = fill_en;

  assign data_we_o       = fill_en;
  assign data_way_mask_o = way_oh;
  // way select only steps the LFSR when the set was full
  assign lfsr_step_o     = fill_en;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // reset goes straight into the walk
      state_q     <= FLUSH;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      flush_q     <= flush_done ? 1'b0 : (flush_q | flush_i);
      flush_cnt_q <= flush_done ? '0 : flush_cnt_q + IdxWidth'(flush_en);
    end
  end

  // request payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
    if (state_q == READ) begin
      way_q <= repl_way_i;
    end
  end

endmodule

/* icache/icache_top.sv */
// instruction cache top level tying the controller, the way arrays and the way selection
module icache_top #(
  parameter int unsigned NumWays = icache_cfg_pkg::NumWaysDef,
  parameter int unsigned NumSets = icache_cfg_pkg::NumSetsDef,
  localparam int unsigned IdxWidth = $clog2(NumSets),
  localparam int unsigned WayWidth = $clog2(NumWays),
  localparam int unsigned TagWidth = icache_cfg_pkg::AddrWidth - IdxWidth
                                     - icache_cfg_pkg::OffsetWidth
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   flush_i,
  // fetch port
  input  logic                                   fetch_req_i,
  input  logic [icache_cfg_pkg::AddrWidth-1:0]   fetch_addr_i,
  output logic                                   fetch_ready_o,
  output logic                                   fetch_valid_o,
  output logic [icache_cfg_pkg::FetchWidth-1:0]  fetch_data_o,
  // refill request
  output logic                                   mem_req_o,
  output logic [icache_cfg_pkg::AddrWidth-1:0]   mem_addr_o,
  output logic [WayWidth-1:0]                    mem_way_o,
  input  logic                                   mem_ack_i,
  // return channel
  input  logic                                   mem_rtrn_vld_i,
  input  icache_mem_pkg::rtrn_type_e             mem_rtrn_type_i,
  input  logic [icache_cfg_pkg::LineWidth-1:0]   mem_rtrn_data_i,
  input  logic                                   mem_rtrn_inv_all_i,
  input  logic [IdxWidth-1:0]                    mem_rtrn_inv_set_i,
  input  logic [WayWidth-1:0]                    mem_rtrn_inv_way_i,
  // performance counter
  output logic                                   miss_o
);

  ////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////

  // array control from the controller
  logic                                          rd_en;
  logic [IdxWidth-1:0]                           index;
  logic [TagWidth-1:0]                           tag;
  logic [icache_cfg_pkg::OffsetWidth-1:0]        offset;
  logic                                          vld_we;
  logic [NumWays-1:0]                            vld_way_mask;
  logic [IdxWidth-1:0]                           vld_index;
  logic                                          vld_set;
  logic                                          data_we;
  logic [NumWays-1:0]                            data_way_mask;
  logic                                          lfsr_step;
  // array read data, one cycle after rd_en
  logic [NumWays-1:0][TagWidth-1:0]              tag_rdata;
  logic [NumWays-1:0]                            vld_rdata;
  logic [NumWays-1:0][icache_cfg_pkg::LineWidth-1:0] line_rdata;
  // lookup result
  logic                                          hit;
  logic [icache_cfg_pkg::FetchWidth-1:0]         hit_word;
  logic [WayWidth-1:0]                           repl_way;

  icache_ctrl #(
    .NumWays ( NumWays ),
    .NumSets ( NumSets )
  ) u_ctrl (
    .clk_i, .rst_ni, .flush_i,
    .fetch_req_i, .fetch_addr_i, .fetch_ready_o, .fetch_valid_o, .fetch_data_o,
    .mem_req_o, .mem_addr_o, .mem_way_o, .mem_ack_i,
    .mem_rtrn_vld_i, .mem_rtrn_type_i, .mem_rtrn_data_i,
    .mem_rtrn_inv_all_i, .mem_rtrn_inv_set_i, .mem_rtrn_inv_way_i,
    .miss_o,
    .hit_i           ( hit           ),
    .hit_word_i      ( hit_word      ),
    .repl_way_i      ( repl_way      ),
    .rd_en_o         ( rd_en         ),
    .index_o         ( index         ),
    .tag_o           ( tag           ),
    .offset_o        ( offset        ),
    .vld_we_o        ( vld_we        ),
    .vld_way_mask_o  ( vld_way_mask  ),
    .vld_index_o     ( vld_index     ),
    .vld_set_o       ( vld_set       ),
    .data_we_o       ( data_we       ),
    .data_way_mask_o ( data_way_mask ),
    .lfsr_step_o     ( lfsr_step     )
  );

  icache_arrays #(
    .NumWays ( NumWays ),
    .NumSets ( NumSets )
  ) u_arrays (
    .clk_i,
    .rd_en_i         ( rd_en           ),
    .index_i         ( index           ),
    .vld_we_i        ( vld_we          ),
    .vld_index_i     ( vld_index       ),
    .vld_way_mask_i  ( vld_way_mask    ),
    .vld_set_i       ( vld_set         ),
    .tag_i           ( tag             ),
    .data_we_i       ( data_we         ),
    .data_way_mask_i ( data_way_mask   ),
    .line_i          ( mem_rtrn_data_i ),
    .tag_rdata_o     ( tag_rdata       ),
    .vld_rdata_o     ( vld_rdata       ),
    .line_rdata_o    ( line_rdata      )
  );

  icache_way_select #(
    .NumWays ( NumWays ),
    .NumSets ( NumSets )
  ) u_way_select (
    .clk_i, .rst_ni,
    .tag_i        ( tag        ),
    .offset_i     ( offset     ),
    .tag_rdata_i  ( tag_rdata  ),
    .vld_rdata_i  ( vld_rdata  ),
    .line_rdata_i ( line_rdata ),
    .lfsr_step_i  ( lfsr_step  ),
    .hit_o        ( hit        ),
    .hit_word_o   ( hit_word   ),
    .repl_way_o   ( repl_way   )
  );

endmodule

/* dv/icache_tb_mem.sv */
// memory responder for the instruction cache testbench with random delays and invalidations
module icache_tb_mem #(
  parameter int unsigned IdxWidth = 4,
  parameter int unsigned WayWidth = 2
) (
  input  logic                                 clk_i,
  input  logic                                 mem_req_i,
  output logic                                 mem_ack_o,
  input  logic [icache_cfg_pkg::LineWidth-1:0] line_i,
  // invalidation injection from the test sequence
  input  logic                                 inv_req_i,
  input  logic                                 inv_all_i,
  input  logic [IdxWidth-1:0]                  inv_set_i,
  input  logic [WayWidth-1:0]                  inv_way_i,
  output logic                                 rtrn_vld_o,
  output icache_mem_pkg::rtrn_type_e           rtrn_type_o,
  output logic [icache_cfg_pkg::LineWidth-1:0] rtrn_data_o,
  output logic                                 rtrn_inv_all_o,
  output logic [IdxWidth-1:0]                  rtrn_inv_set_o,
  output logic [WayWidth-1:0]                  rtrn_inv_way_o
);

  logic [15:0]                          lfsr_q;
  // 0 idle, 1 ack delay, 2 return delay
  int                                   phase;
  int                                   wait_cnt;
  logic [icache_cfg_pkg::LineWidth-1:0] line_q;
  logic                                 nxt_ack, nxt_vld, nxt_all;
  icache_mem_pkg::rtrn_type_e           nxt_type;
  logic [IdxWidth-1:0]                  nxt_set;
  logic [WayWidth-1:0]                  nxt_way;

  // 16 bit fibonacci, taps 16 14 13 11, one step per bit
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      v = (v << 1) | int'(lfsr_q[0]);
    end
    return v;
  endfunction

  initial begin
    lfsr_q         = 16'd44211;
    phase          = 0;
    wait_cnt       = 0;
    line_q         = '0;
    mem_ack_o      = 1'b0;
    rtrn_vld_o     = 1'b0;
    rtrn_type_o    = icache_mem_pkg::RTRN_IFILL;
    rtrn_data_o    = '0;
    rtrn_inv_all_o = 1'b0;
    rtrn_inv_set_o = '0;
    rtrn_inv_way_o = '0;
    forever begin
      // decide on settled values mid cycle
      @(negedge clk_i);
      nxt_ack  = 1'b0;
      nxt_vld  = 1'b0;
      nxt_type = icache_mem_pkg::RTRN_IFILL;
      nxt_all  = inv_all_i;
      nxt_set  = inv_set_i;
      nxt_way  = inv_way_i;
      if (inv_req_i) begin
        nxt_vld  = 1'b1;
        nxt_type = icache_mem_pkg::RTRN_INV;
      end
      if (phase == 0 && mem_req_i) begin
        phase    = 1;
        wait_cnt = take_bits(2);
      end
      if (phase == 1) begin
        if (wait_cnt == 0) begin
          // line address is stable while the request waits
          nxt_ack  = 1'b1;
          line_q   = line_i;
          phase    = 2;
          wait_cnt = take_bits(2);
        end else begin
          wait_cnt--;
        end
      end else if (phase == 2) begin
        if (wait_cnt == 0) begin
          nxt_vld = 1'b1;
          phase   = 0;
        end else begin
          wait_cnt--;
        end
      end
      // apply shortly after the next rising edge
      @(posedge clk_i);
      #1;
      mem_ack_o      = nxt_ack;
      rtrn_vld_o     = nxt_vld;
      rtrn_type_o    = nxt_type;
      rtrn_data_o    = line_q;
      rtrn_inv_all_o = nxt_all;
      rtrn_inv_set_o = nxt_set;
      rtrn_inv_way_o = nxt_way;
    end
  end

endmodule

/* dv/icache_tb.sv */
// testbench for the instruction cache with a line reference model and assertion checks
module icache_tb;

  localparam int unsigned NumWays  = icache_cfg_pkg::NumWaysDef;
  localparam int unsigned NumSets  = icache_cfg_pkg::NumSetsDef;
  localparam int unsigned AddrW    = icache_cfg_pkg::AddrWidth;
  localparam int unsigned FetchW   = icache_cfg_pkg::FetchWidth;
  localparam int unsigned LineW    = icache_cfg_pkg::LineWidth;
  localparam int unsigned OffW     = icache_cfg_pkg::OffsetWidth;
  localparam int unsigned IdxWidth = $clog2(NumSets);
  localparam int unsigned WayWidth = $clog2(NumWays);
  localparam int unsigned TagShift = IdxWidth + OffW;
  // 2 + 4 + 10 + 8 + 3 fetches, reset walk plus one requested walk
  localparam int unsigned NumFetches = 27;
  localparam int unsigned CycleLimit = 40 * NumFetches + 2 * (NumSets + 1);

  logic                  clk_i, rst_ni, flush_i, fetch_req_i;
  logic [AddrW-1:0]      fetch_addr_i, mem_addr_o;
  logic                  fetch_ready_o, fetch_valid_o, mem_req_o, mem_ack_i, miss_o;
  logic [FetchW-1:0]     fetch_data_o;
  logic [WayWidth-1:0]   mem_way_o, mem_rtrn_inv_way_i, inv_way;
  logic                  mem_rtrn_vld_i, mem_rtrn_inv_all_i, inv_req, inv_all;
  icache_mem_pkg::rtrn_type_e mem_rtrn_type_i;
  logic [LineW-1:0]      mem_rtrn_data_i, fill_line;
  logic [IdxWidth-1:0]   mem_rtrn_inv_set_i, inv_set;

  // reference model of present lines
  logic        model_vld [NumSets][NumWays];
  int unsigned model_tag [NumSets][NumWays];
  int unsigned tag_save  [NumWays];
  // monitor state for the fetch in flight
  logic             pend, exp_hit, seen_ack, low_watch;
  logic [AddrW-1:0] pend_addr;
  int               exp_way, fill_way, acc_cyc, low_cnt, exp_low, gone;
  int               cyc = 0;
  int               checks = 0;
  int               errors = 0;
  int               test_cnt = 0;
  int               checks_at, errors_at;
  string            test_name;

  icache_top u_dut (.*);

  icache_tb_mem #(.IdxWidth(IdxWidth), .WayWidth(WayWidth)) u_mem (
    .clk_i, .mem_req_i(mem_req_o), .mem_ack_o(mem_ack_i), .line_i(fill_line),
    .inv_req_i(inv_req), .inv_all_i(inv_all), .inv_set_i(inv_set), .inv_way_i(inv_way),
    .rtrn_vld_o(mem_rtrn_vld_i), .rtrn_type_o(mem_rtrn_type_i), .rtrn_data_o(mem_rtrn_data_i),
    .rtrn_inv_all_o(mem_rtrn_inv_all_i), .rtrn_inv_set_o(mem_rtrn_inv_set_i),
    .rtrn_inv_way_o(mem_rtrn_inv_way_i)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////
  // memory contents and model lookups
  ////////////////////////////////////////

  // every word is a fixed function of its own address
  function automatic logic [FetchW-1:0] word_of(input logic [AddrW-1:0] addr);
    return {addr[AddrW-1:2], 2'b00} ^ 32'hc3a5_5a3c;
  endfunction

  function automatic logic [LineW-1:0] line_of(input logic [AddrW-1:0] addr);
    logic [LineW-1:0] line;
    for (int k = 0; k < LineW / FetchW; k++) begin
      line[k * FetchW +: FetchW] = word_of(addr + AddrW'(4 * k));
    end
    return line;
  endfunction

  assign fill_line = line_of(mem_addr_o);

  function automatic logic [AddrW-1:0] mk_addr(input int unsigned tag, input int idx,
                                                 input int word);
    return AddrW'((tag << TagShift) | (idx << OffW) | (word << 2));
  endfunction

  function automatic int find_way(input logic [AddrW-1:0] addr);
    int idx;
    idx = int'(addr[OffW +: IdxWidth]);
    for (int w = 0; w < NumWays; w++) begin
      if (model_vld[idx][w] && model_tag[idx][w] == (addr >> TagShift)) return w;
    end
    return -1;
  endfunction

  // -1 once the set is full, the LFSR victim is then taken as shown
  function automatic int lowest_invalid(input logic [AddrW-1:0] addr);
    int idx;
    idx = int'(addr[OffW +: IdxWidth]);
    for (int w = 0; w < NumWays; w++) begin
      if (!model_vld[idx][w]) return w;
    end
    return -1;
  endfunction

  task automatic clear_model();
    for (int s = 0; s < NumSets; s++) begin
      for (int w = 0; w < NumWays; w++) model_vld[s][w] = 1'b0;
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_cond(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("ERROR in %s: %s", test_name, what);
    end
  endtask

  ////////////////////////////////////////
  // monitor, sampled mid cycle
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      clear_model();
      pend      = 1'b0;
      low_watch = 1'b1;
      low_cnt   = 0;
      exp_low   = NumSets;
    end else begin
      // ready comes back only after the whole walk
      if (low_watch) begin
        if (fetch_ready_o) begin
          check_value("ready-low cycles", exp_low, low_cnt);
          low_watch = 1'b0;
        end else begin
          low_cnt++;
        end
      end
      // pending register costs one idle cycle before the walk
      if (flush_i) begin
        clear_model();
        low_watch = 1'b1;
        low_cnt   = 0;
        exp_low   = NumSets + 1;
      end
      if (mem_rtrn_vld_i) begin
        check_cond(!fetch_ready_o, "fetch_ready_o high while a return is valid");
        if (mem_rtrn_type_i == icache_mem_pkg::RTRN_INV) begin
          for (int w = 0; w < NumWays; w++) begin
            if (mem_rtrn_inv_all_i || w == int'(mem_rtrn_inv_way_i)) begin
              model_vld[mem_rtrn_inv_set_i][w] = 1'b0;
            end
          end
        end
      end
      if (mem_req_o) begin
        check_cond(pend && !exp_hit, "refill requested for a line that should hit");
      end
      check_cond(miss_o == mem_ack_i, "miss_o does not pulse with the acknowledge");
      if (mem_ack_i) begin
        check_cond(mem_req_o, "acknowledge came after the refill request was dropped");
        check_value("refill address", {pend_addr[AddrW-1:OffW], OffW'(0)}, mem_addr_o);
        if (exp_way >= 0) check_value("refill way", exp_way, 32'(mem_way_o));
        seen_ack = 1'b1;
        fill_way = int'(mem_way_o);
      end
      if (fetch_valid_o) begin
        check_cond(pend, "fetch_valid_o without an accepted fetch");
        check_value("fetch data", word_of(pend_addr), fetch_data_o);
        if (exp_hit) begin
          check_value("hit latency", acc_cyc + 1, cyc);
        end else begin
          check_cond(seen_ack, "miss answered without a refill");
          check_cond(mem_rtrn_vld_i && mem_rtrn_type_i == icache_mem_pkg::RTRN_IFILL,
                     "miss answered outside the refill return cycle");
          model_vld[pend_addr[OffW +: IdxWidth]][fill_way] = 1'b1;
          model_tag[pend_addr[OffW +: IdxWidth]][fill_way] = pend_addr >> TagShift;
        end
        pend = 1'b0;
      end
      if (fetch_req_i && fetch_ready_o) begin
        pend      = 1'b1;
        pend_addr = fetch_addr_i;
        exp_hit   = find_way(fetch_addr_i) >= 0;
        exp_way   = lowest_invalid(fetch_addr_i);
        acc_cyc   = cyc;
        seen_ack  = 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    cyc++;
    if (cyc > CycleLimit) begin
      $display("timeout after %0d cycles, the cache stopped answering", cyc);
      $display("Test FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic fetch(input logic [AddrW-1:0] addr);
    @(posedge clk_i);
    #1;
    fetch_req_i  = 1'b1;
    fetch_addr_i = addr;
    do @(negedge clk_i); while (!fetch_ready_o);
    @(posedge clk_i);
    #1;
    fetch_req_i = 1'b0;
    do @(negedge clk_i); while (!fetch_valid_o);
  endtask

  task automatic send_inv(input int idx, input int way, input logic all);
    @(posedge clk_i);
    #1;
    inv_req = 1'b1;
    inv_all = all;
    inv_set = IdxWidth'(idx);
    inv_way = WayWidth'(way);
    @(posedge clk_i);
    #1;
    inv_req = 1'b0;
  endtask

  task automatic send_flush();
    @(posedge clk_i);
    #1;
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    do @(negedge clk_i); while (!fetch_ready_o);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_cnt++;
    checks_at = checks;
    errors_at = errors;
  endtask

  task automatic end_test();
    $display("%s: %0d checks, %0d errors", test_name, checks - checks_at, errors - errors_at);
  endtask

  initial begin
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    inv_req      = 1'b0;
    inv_all      = 1'b0;
    inv_set      = '0;
    inv_way      = '0;
    begin_test("cold_miss");
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    fetch(mk_addr(1, 2, 1));
    fetch(mk_addr(1, 5, 3));
    end_test();

    begin_test("hit");
    for (int w = 0; w < 4; w++) fetch(mk_addr(1, 2, w));
    end_test();

    // fill set 3, then one more tag forces an eviction
    begin_test("way_choice");
    for (int t = 0; t <= NumWays; t++) fetch(mk_addr(10 + t, 3, t % 4));
    gone = -1;
    for (int t = 0; t <= NumWays; t++) begin
      if (find_way(mk_addr(10 + t, 3, 0)) < 0) gone = t;
    end
    for (int t = 0; t <= NumWays; t++) begin
      if (t != gone) fetch(mk_addr(10 + t, 3, 1));
    end
    fetch(mk_addr(10 + gone, 3, 2));
    end_test();

    begin_test("invalidation");
    for (int w = 0; w < NumWays; w++) tag_save[w] = model_tag[3][w];
    send_inv(3, 2, 1'b0);
    for (int w = 0; w < NumWays; w++) begin
      if (w != 2) fetch(mk_addr(tag_save[w], 3, w % 4));
    end
    fetch(mk_addr(tag_save[2], 3, 0));
    send_inv(3, 0, 1'b1);
    for (int w = 0; w < NumWays; w++) fetch(mk_addr(tag_save[w], 3, 3));
    end_test();

    begin_test("flush");
    send_flush();
    fetch(mk_addr(1, 2, 0));
    fetch(mk_addr(1, 5, 0));
    fetch(mk_addr(tag_save[0], 3, 2));
    end_test();

    $display("%0d tests, %0d checks, %0d errors", test_cnt, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* icache_top.f */
common/icache_cfg_pkg.sv
common/icache_mem_pkg.sv
icache/icache_arrays.sv
icache/icache_way_select.sv
icache/icache_ctrl.sv
icache/icache_top.sv
dv/icache_tb_mem.sv
dv/icache_tb.sv
